// File: hrmfCore.f
hdl/hrmfPkg.sv
hdl/laneBus.sv
hdl/radix4Butterfly.sv
hdl/constRotator.sv
hdl/delayCommutator.sv
hdl/transposeUnit.sv
hdl/hrmfCore.sv
sim/hrmfCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the hrmfCore testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module hrmfCoreTb \
    -f hrmfCore.f \
    -o hrmfCoreSim

status=0
./obj_dir/hrmfCoreSim > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
grep -q "Result: PASSED" "$LOG"

// File: sim/hrmfCoreTb.sv
`timescale 1ns/100ps

module hrmfCoreTb
    import hrmfPkg::*;
();

    typedef logic [numLanes-1:0][2*partW-1:0] laneSet;

    localparam int resetCycles = 16;
    localparam int latency = 3;
    localparam int streamLen = 20;
    localparam int numHeld = 3;
    localparam int holdCycles = 12;
    localparam int settleCycles = 8;
    // Twice the expected run plus margin
    localparam int cycleLimit =
        2 * (resetCycles + 8 + 2 * (streamLen + latency) + numHeld * holdCycles) + 38;

    logic CLK;
    logic RSTn;
    selWord sel;
    laneSet dIn;
    wire laneSet qOut;

    int seed = 32'h1c2c_35d0;
    int cycleCount = 0;

    selWord streamSel [streamLen];
    laneSet streamIn [streamLen];
    laneSet streamExp [streamLen];
    selWord heldSel [numHeld];
    laneSet heldIn [numHeld];
    laneSet heldExp [numHeld];
    laneSet impulseIn;
    laneSet impulseExp;

    hrmfCore dut_i (
        .CLK  (CLK),
        .RSTn (RSTn),
        .sel  (sel),
        .d0   (dIn[0]),
        .d1   (dIn[1]),
        .d2   (dIn[2]),
        .d3   (dIn[3]),
        .q0   (qOut[0]),
        .q1   (qOut[1]),
        .q2   (qOut[2]),
        .q3   (qOut[3])
    );

    initial CLK = 1'b0;
    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the test did not finish within %0d clock cycles", cycleLimit);
            $display("Result: FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    function automatic cpxWord fromInts(int re, int im);
        return {re <<< fracW, im <<< fracW};
    endfunction

    // Product with cos - j*sin, each term cut back to Q16.16 on its own
    function automatic cpxWord twiddleProduct(cpxWord x, cpxWord tw);
        logic signed [2*partW-1:0] full [4];
        full[0] = 64'(reOf(x)) * 64'(reOf(tw));
        full[1] = 64'(imOf(x)) * 64'(imOf(tw));
        full[2] = 64'(imOf(x)) * 64'(reOf(tw));
        full[3] = 64'(reOf(x)) * 64'(imOf(tw));
        return mkCpx(part'(full[0][47:16]) + part'(full[1][47:16]),
                     part'(full[2][47:16]) - part'(full[3][47:16]));
    endfunction

    function automatic laneSet butterfly(laneSet x);
        cpxWord t0;
        cpxWord t1;
        cpxWord t2;
        cpxWord t3;
        laneSet y;
        t0 = cAdd(x[0], x[2]);
        t1 = cAdd(x[1], x[3]);
        t2 = cSub(x[0], x[2]);
        t3 = cNegJ(cSub(x[1], x[3]));
        y[0] = cAdd(t0, t1);
        y[1] = cAdd(t2, t3);
        y[2] = cSub(t0, t1);
        y[3] = cSub(t2, t3);
        return y;
    endfunction

    function automatic laneSet rotate(laneSet x, selWord s);
        laneSet y;
        y = x;
        for (int p = 1; p < numLanes; p++) begin
            if (s[0])
                y[p] = twiddleProduct(y[p], twiddleTab[p]);
            if (s[1])
                y[p] = twiddleProduct(y[p], twiddleTab[2*p]);
        end
        return y;
    endfunction

    // Steady state of the transpose, bit 1 swaps lanes two apart
    function automatic laneSet swapLanes(laneSet x, selWord s);
        laneSet mid;
        laneSet y;
        for (int i = 0; i < numLanes; i++) begin
            mid[i] = s[1] ? x[i ^ 2] : x[i];
        end
        for (int i = 0; i < numLanes; i++) begin
            y[i] = s[0] ? mid[i ^ 1] : mid[i];
        end
        return y;
    endfunction

    function automatic laneSet expectedOut(laneSet x, selWord s);
        return butterfly(swapLanes(rotate(butterfly(x), s), s));
    endfunction

    task automatic buildTables();
        for (int i = 0; i < streamLen; i++) begin
            streamSel[i] = '0;
            for (int k = 0; k < numLanes; k++) begin
                streamIn[i][k] = fromInts($random(seed) % 501, $random(seed) % 501);
            end
        end
        // Hand-picked sets lead the stream
        streamIn[0] = {fromInts(1, 0), fromInts(1, 0), fromInts(1, 0), fromInts(1, 0)};
        streamIn[1] = {64'h0000_8000_ffff_8000, fromInts(0, 2), fromInts(-1, 0), 64'd0};
        streamIn[2] = {fromInts(-500, -500), fromInts(500, 500), fromInts(-500, 0), 64'd0};
        heldIn[0] = {fromInts(7, -2), fromInts(-3, 5), fromInts(1, 1), fromInts(2, 0)};
        heldIn[1] = {fromInts(-12, 4), fromInts(6, 6), fromInts(0, -9), fromInts(10, 3)};
        heldIn[2] = {fromInts(100, -50), fromInts(-25, 75), fromInts(40, 8), fromInts(-60, -1)};
        for (int i = 0; i < streamLen; i++) begin
            streamExp[i] = expectedOut(streamIn[i], streamSel[i]);
        end
        for (int g = 0; g < numHeld; g++) begin
            heldSel[g] = selWord'(g + 1);
            heldExp[g] = expectedOut(heldIn[g], heldSel[g]);
        end
        // 3.5 on lane 0 alone comes out as 14 on q0
        impulseIn = {192'd0, 64'h0003_8000_0000_0000};
        impulseExp = {192'd0, 64'h000e_0000_0000_0000};
    endtask

    task automatic drive(selWord s, laneSet x);
        @(posedge CLK);
        sel <= s;
        dIn <= x;
    endtask

    task automatic checkSet(laneSet expSet);
        for (int i = 0; i < numLanes; i++) begin
            assert (qOut[i] === expSet[i]) else begin
                $display("FAIL time=%0t q%0d expected=%h actual=%h",
                         $time, i, expSet[i], qOut[i]);
                $display("Result: FAILED");
                $fatal(1, "Output mismatch on q%0d", i);
            end
        end
    endtask

    // One new set per cycle, each checked once it has crossed the pipeline
    task automatic runStream();
        for (int i = 0; i < streamLen + latency; i++) begin
            if (i < streamLen)
                drive(streamSel[i], streamIn[i]);
            else
                drive('0, '0);
            @(negedge CLK);
            if (i >= latency)
                checkSet(streamExp[i - latency]);
        end
    endtask

    initial begin
        RSTn = 1'b0;
        sel = '0;
        dIn = '0;
        buildTables();
        repeat (resetCycles) begin
            @(negedge CLK);
            checkSet('0);
        end
        @(posedge CLK);
        RSTn <= 1'b1;
        repeat (2) begin
            drive('0, '0);
            @(negedge CLK);
            checkSet('0);
        end

        for (int c = 0; c <= latency + 1; c++) begin
            if (c == 0)
                drive('0, impulseIn);
            else
                drive('0, '0);
            @(negedge CLK);
            checkSet(c == latency ? impulseExp : '0);
        end

        runStream();

        // Held groups, checked once the commutators have settled
        for (int g = 0; g < numHeld; g++) begin
            for (int c = 0; c < holdCycles; c++) begin
                drive(heldSel[g], heldIn[g]);
                @(negedge CLK);
                if (c >= settleCycles)
                    checkSet(heldExp[g]);
            end
        end

        runStream();

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: hdl/hrmfCore.sv
`timescale 1ns/100ps

module hrmfCore
    import hrmfPkg::*;
(
    input  logic   CLK,
    input  logic   RSTn,
    input  selWord sel,
    input  cpxWord d0,
    input  cpxWord d1,
    input  cpxWord d2,
    input  cpxWord d3,
    output cpxWord q0,
    output cpxWord q1,
    output cpxWord q2,
    output cpxWord q3
);

    laneBus bfIn ();
    laneBus rotOut ();
    laneBus trOut ();
    // Output side of the second butterfly
    laneBus bfOut ();

    radix4Butterfly firstBf (
        .d0  (d0),
        .d1  (d1),
        .d2  (d2),
        .d3  (d3),
        .out (bfIn.src)
    );

    constRotator rotator (
        .sel (sel),
        .in  (bfIn.snk),
        .out (rotOut.src)
    );

    transposeUnit transpose (
        .CLK  (CLK),
        .RSTn (RSTn),
        .sel  (sel),
        .in   (rotOut.snk),
        .out  (trOut.src)
    );

    radix4Butterfly secondBf (
        .d0  (trOut.lane[0]),
        .d1  (trOut.lane[1]),
        .d2  (trOut.lane[2]),
        .d3  (trOut.lane[3]),
        .out (bfOut.src)
    );

    assign q0 = bfOut.lane[0];
    assign q1 = bfOut.lane[1];
    assign q2 = bfOut.lane[2];
    assign q3 = bfOut.lane[3];

endmodule

// File: hdl/transposeUnit.sv
`timescale 1ns/100ps

module transposeUnit
    import hrmfPkg::*;
(
    input  logic   CLK,
    input  logic   RSTn,
    input  selWord sel,
    laneBus.snk    in,
    laneBus.src    out
);

    cpxWord midLane [numLanes];

    // Stage one, lanes two apart, driven by sel bit 1
    delayCommutator #(.DELAY(2)) stageOnePair0 (
        .CLK  (CLK),
        .RSTn (RSTn),
        .sel  (sel[1]),
        .in0  (in.lane[0]),
        .in1  (in.lane[2]),
        .out0 (midLane[0]),
        .out1 (midLane[2])
    );

    delayCommutator #(.DELAY(2)) stageOnePair1 (
        .CLK  (CLK),
        .RSTn (RSTn),
        .sel  (sel[1]),
        .in0  (in.lane[1]),
        .in1  (in.lane[3]),
        .out0 (midLane[1]),
        .out1 (midLane[3])
    );

    // Stage two, neighbouring lanes, driven by sel bit 0
    delayCommutator #(.DELAY(1)) stageTwoPair0 (
        .CLK  (CLK),
        .RSTn (RSTn),
        .sel  (sel[0]),
        .in0  (midLane[0]),
        .in1  (midLane[1]),
        .out0 (out.lane[0]),
        .out1 (out.lane[1])
    );

    delayCommutator #(.DELAY(1)) stageTwoPair1 (
        .CLK  (CLK),
        .RSTn (RSTn),
        .sel  (sel[0]),
        .in0  (midLane[2]),
        .in1  (midLane[3]),
        .out0 (out.lane[2]),
        .out1 (out.lane[3])
    );

endmodule

// File: hdl/delayCommutator.sv
`timescale 1ns/100ps

module delayCommutator
    import hrmfPkg::*;
#(
    parameter int DELAY = 1
)(
    input  logic   CLK,
    input  logic   RSTn,
    input  logic   sel,
    input  cpxWord in0,
    input  cpxWord in1,
    output cpxWord out0,
    output cpxWord out1
);

    cpxWord firstReg [DELAY];
    cpxWord secondReg [DELAY];
    cpxWord secondFeed;

    // in1 always enters the first delay line
    always_ff @(posedge CLK or negedge RSTn) begin
        if (!RSTn) begin
            for (int i = 0; i < DELAY; i++) begin
                firstReg[i] <= '0;
            end
        end else begin
            firstReg[0] <= in1;
            for (int i = 1; i < DELAY; i++) begin
                firstReg[i] <= firstReg[i-1];
            end
        end
    end

    // Swap routes the first line into the second, in0 bypasses
    assign secondFeed = sel ? firstReg[DELAY-1] : in0;

    always_ff @(posedge CLK or negedge RSTn) begin
        if (!RSTn) begin
            for (int i = 0; i < DELAY; i++) begin
                secondReg[i] <= '0;
            end
        end else begin
            secondReg[0] <= secondFeed;
            for (int i = 1; i < DELAY; i++) begin
                secondReg[i] <= secondReg[i-1];
            end
        end
    end

    assign out0 = secondReg[DELAY-1];
    assign out1 = sel ? in0 : firstReg[DELAY-1];

    selKnown: assert property (
        @(posedge CLK) disable iff (!RSTn) !$isunknown(sel)
    );

endmodule

// File: hdl/constRotator.sv
`timescale 1ns/100ps

module constRotator
    import hrmfPkg::*;
(
    input  selWord sel,
    laneBus.snk    in,
    laneBus.src    out
);

    // Lane 0 always sees the unit twiddle
    assign out.lane[0] = in.lane[0];

    for (genvar p = 1; p < numLanes; p++) begin : gLane
        cpxWord rotOne;
        cpxWord stepOne;
        cpxWord rotTwo;

        // Step one by W16^p
        assign rotOne = cMulTw(in.lane[p], twiddleTab[p]);
        assign stepOne = sel[0] ? rotOne : in.lane[p];

        // Step two by W16^2p on top of step one
        assign rotTwo = cMulTw(stepOne, twiddleTab[2*p]);
        assign out.lane[p] = sel[1] ? rotTwo : stepOne;
    end

endmodule

// File: hdl/radix4Butterfly.sv
`timescale 1ns/100ps

module radix4Butterfly
    import hrmfPkg::*;
(
    input  cpxWord d0,
    input  cpxWord d1,
    input  cpxWord d2,
    input  cpxWord d3,
    laneBus.src    out
);

    cpxWord t0;
    cpxWord t1;
    cpxWord t2;
    cpxWord t3;
    cpxWord oddDiff;

    // First radix-2 layer on the even and odd pairs
    assign t0 = cAdd(d0, d2);
    assign t2 = cSub(d0, d2);
    assign t1 = cAdd(d1, d3);
    assign oddDiff = cSub(d1, d3);

    // W4 twiddle is a plain swap and negate
    assign t3 = cNegJ(oddDiff);

    // Second layer, outputs in natural order
    assign out.lane[0] = cAdd(t0, t1);
    assign out.lane[1] = cAdd(t2, t3);
    assign out.lane[2] = cSub(t0, t1);
    assign out.lane[3] = cSub(t2, t3);

endmodule

// File: hdl/laneBus.sv
`timescale 1ns/100ps

interface laneBus
    import hrmfPkg::*;
();

    // One complex sample per lane
    cpxWord lane [numLanes];

    modport src (
        output lane
    );

    modport snk (
        input lane
    );

endinterface

// File: hdl/hrmfPkg.sv
package hrmfPkg;

    localparam int partW = 32;
    localparam int fracW = 16;
    localparam int numLanes = 4;
    localparam int selW = 2;

    // Real part in the upper half, imaginary part in the lower half
    typedef logic [2*partW-1:0] cpxWord;
    typedef logic signed [partW-1:0] part;
    typedef logic [selW-1:0] selWord;

    // Cosine and sine of 2*pi*k/16 in Q16.16
    localparam cpxWord twiddleTab [8] = '{
        64'h0001_0000_0000_0000,
        64'h0000_ec83_0000_61f7,
        64'h0000_b504_0000_b504,
        64'h0000_61f7_0000_ec83,
        64'h0000_0000_0001_0000,
        64'hffff_9e09_0000_ec83,
        64'hffff_4afc_0000_b504,
        64'hffff_137d_0000_61f7
    };

    function automatic part reOf(cpxWord x);
        return part'(x[2*partW-1:partW]);
    endfunction

    function automatic part imOf(cpxWord x);
        return part'(x[partW-1:0]);
    endfunction

    function automatic cpxWord mkCpx(part re, part im);
        return {re, im};
    endfunction

    function automatic cpxWord cAdd(cpxWord a, cpxWord b);
        return mkCpx(reOf(a) + reOf(b), imOf(a) + imOf(b));
    endfunction

    function automatic cpxWord cSub(cpxWord a, cpxWord b);
        return mkCpx(reOf(a) - reOf(b), imOf(a) - imOf(b));
    endfunction

    // Multiply by -j
    function automatic cpxWord cNegJ(cpxWord a);
        return mkCpx(imOf(a), -reOf(a));
    endfunction

    // Twiddle holds cos and sin, so the product is with cos - j*sin
    function automatic cpxWord cMulTw(cpxWord d, cpxWord tw);
        logic signed [2*partW-1:0] prodRc;
        logic signed [2*partW-1:0] prodIs;
        logic signed [2*partW-1:0] prodIc;
        logic signed [2*partW-1:0] prodRs;
        part re;
        part im;
        prodRc = reOf(d) * reOf(tw);
        prodIs = imOf(d) * imOf(tw);
        prodIc = imOf(d) * reOf(tw);
        prodRs = reOf(d) * imOf(tw);
        // Each product drops back to Q16.16 before the sum
        re = part'(prodRc[partW+fracW-1:fracW]) + part'(prodIs[partW+fracW-1:fracW]);
        im = part'(prodIc[partW+fracW-1:fracW]) - part'(prodRs[partW+fracW-1:fracW]);
        return mkCpx(re, im);
    endfunction

endpackage
